//--- logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // Major opcodes of the kept instructions
    localparam logic [6:0] op_rtype     = 7'b0110011;
    localparam logic [6:0] op_itype_alu = 7'b0010011;
    localparam logic [6:0] op_load      = 7'b0000011;
    localparam logic [6:0] op_store     = 7'b0100011;
    localparam logic [6:0] op_branch    = 7'b1100011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_lw      = 3'b010;
    localparam logic [2:0] f3_sw      = 3'b010;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    // ADDI x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } rtype_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } itype_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } stype_t;

    // Scattered branch offset bits with bit 0 implied zero
    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [6:0]            opcode;
    } btype_t;

    typedef union packed {
        rtype_t r;
        itype_t i;
        stype_t s;
        btype_t b;
    } instr_u;

endpackage

`default_nettype wire

//--- logic/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef logic [rv_isa_pkg::xlen-1:0]       word_t;
    typedef logic [rv_isa_pkg::reg_addr_w-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        fwd_reg,
        fwd_exmem,
        fwd_wb
    } fwd_sel_e;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     rd_we;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        alu_op_e  alu_op;
        logic     use_imm;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        logic     branch_ne;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     rd_we;
        word_t    result;
        word_t    store_data;
        logic     is_load;
        logic     is_store;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     rd_we;
        logic     is_load;
        word_t    result;
        word_t    load_data;
    } mem_wb_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    value;
    } wb_t;

    typedef struct packed {
        logic  rd_en;
        logic  wr_en;
        word_t addr;
        word_t wr_data;
    } mem_req_t;

endpackage

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [rv_isa_pkg::xlen-1:0]  instr,
    input  logic                         stall,
    input  logic                         branch_taken,
    input  logic [rv_isa_pkg::xlen-1:0]  branch_target,
    output logic [rv_isa_pkg::xlen-1:0]  pc,
    output logic [rv_isa_pkg::xlen-1:0]  if_pc,
    output rv_isa_pkg::instr_u           if_instr
);

    // Flush wins over a load-use hold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= '0;
            if_pc    <= '0;
            if_instr <= rv_isa_pkg::nop_instr;
        end else if (branch_taken) begin
            pc       <= branch_target;
            if_pc    <= pc;
            if_instr <= rv_isa_pkg::nop_instr;
        end else if (!stall) begin
            pc       <= pc + 32'd4;
            if_pc    <= pc;
            if_instr <= instr;
        end
    end

    // Branch targets from execute must keep the fetch address aligned
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00
    );

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic               clk,
    input  logic               arst_n,
    input  pipe_pkg::reg_idx_t rs1,
    input  pipe_pkg::reg_idx_t rs2,
    input  pipe_pkg::wb_t      wb,
    output pipe_pkg::word_t    rs1_val,
    output pipe_pkg::word_t    rs2_val
);

    // x0 has no storage
    pipe_pkg::word_t regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.rd != '0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // Same-cycle write shows up on the read port
    function automatic pipe_pkg::word_t read_port(input pipe_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wb.we && wb.rd == idx) begin
            return wb.value;
        end
        return regs[idx];
    endfunction

    assign rs1_val = read_port(rs1);
    assign rs2_val = read_port(rs2);

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [rv_isa_pkg::xlen-1:0] if_pc,
    input  rv_isa_pkg::instr_u          if_instr,
    input  pipe_pkg::word_t             rs1_val,
    input  pipe_pkg::word_t             rs2_val,
    input  logic                        branch_taken,
    output pipe_pkg::reg_idx_t          rs1,
    output pipe_pkg::reg_idx_t          rs2,
    output logic                        stall,
    output pipe_pkg::id_ex_t            id_ex
);

    pipe_pkg::id_ex_t  dec;
    pipe_pkg::alu_op_e r_op;
    logic              r_ok;
    pipe_pkg::word_t   imm_i;
    pipe_pkg::word_t   imm_s;
    pipe_pkg::word_t   imm_b;

    assign imm_i = {{20{if_instr.i.imm[11]}}, if_instr.i.imm};
    assign imm_s = {{20{if_instr.s.imm_hi[6]}}, if_instr.s.imm_hi, if_instr.s.imm_lo};
    assign imm_b = {{19{if_instr.b.imm12}}, if_instr.b.imm12, if_instr.b.imm11,
                    if_instr.b.imm10_5, if_instr.b.imm4_1, 1'b0};

    // Register-register group
    always_comb begin
        r_ok = 1'b1;
        r_op = pipe_pkg::alu_add;
        case ({if_instr.r.funct7, if_instr.r.funct3})
            {rv_isa_pkg::f7_base, rv_isa_pkg::f3_add_sub}: r_op = pipe_pkg::alu_add;
            {rv_isa_pkg::f7_sub,  rv_isa_pkg::f3_add_sub}: r_op = pipe_pkg::alu_sub;
            {rv_isa_pkg::f7_base, rv_isa_pkg::f3_and}:     r_op = pipe_pkg::alu_and;
            {rv_isa_pkg::f7_base, rv_isa_pkg::f3_or}:      r_op = pipe_pkg::alu_or;
            {rv_isa_pkg::f7_base, rv_isa_pkg::f3_xor}:     r_op = pipe_pkg::alu_xor;
            {rv_isa_pkg::f7_base, rv_isa_pkg::f3_slt}:     r_op = pipe_pkg::alu_slt;
            default:                                       r_ok = 1'b0;
        endcase
    end

    // Anything not kept stays an all-zero record, which behaves as a NOP
    always_comb begin
        dec       = '0;
        dec.valid = 1'b1;
        dec.pc    = if_pc;
        case (if_instr.r.opcode)
            rv_isa_pkg::op_rtype: begin
                if (r_ok) begin
                    dec.rs1    = if_instr.r.rs1;
                    dec.rs2    = if_instr.r.rs2;
                    dec.rd     = if_instr.r.rd;
                    dec.rd_we  = 1'b1;
                    dec.alu_op = r_op;
                end
            end
            rv_isa_pkg::op_itype_alu, rv_isa_pkg::op_load: begin
                if ((if_instr.i.opcode == rv_isa_pkg::op_load)
                        ? (if_instr.i.funct3 == rv_isa_pkg::f3_lw)
                        : (if_instr.i.funct3 == rv_isa_pkg::f3_add_sub)) begin
                    dec.rs1     = if_instr.i.rs1;
                    dec.rd      = if_instr.i.rd;
                    dec.rd_we   = 1'b1;
                    dec.imm     = imm_i;
                    dec.use_imm = 1'b1;
                    dec.is_load = (if_instr.i.opcode == rv_isa_pkg::op_load);
                end
            end
            rv_isa_pkg::op_store: begin
                if (if_instr.s.funct3 == rv_isa_pkg::f3_sw) begin
                    dec.rs1      = if_instr.s.rs1;
                    dec.rs2      = if_instr.s.rs2;
                    dec.imm      = imm_s;
                    dec.use_imm  = 1'b1;
                    dec.is_store = 1'b1;
                end
            end
            rv_isa_pkg::op_branch: begin
                if (if_instr.b.funct3 == rv_isa_pkg::f3_beq ||
                    if_instr.b.funct3 == rv_isa_pkg::f3_bne) begin
                    dec.rs1       = if_instr.b.rs1;
                    dec.rs2       = if_instr.b.rs2;
                    dec.imm       = imm_b;
                    dec.is_branch = 1'b1;
                    dec.branch_ne = (if_instr.b.funct3 == rv_isa_pkg::f3_bne);
                end
            end
            default: ;
        endcase
    end

    assign rs1 = dec.rs1;
    assign rs2 = dec.rs2;

    // Unused sources are x0, so they never match a load destination
    assign stall = id_ex.valid && id_ex.is_load && id_ex.rd != '0 &&
                   (id_ex.rd == dec.rs1 || id_ex.rd == dec.rs2);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (stall || branch_taken) begin
            id_ex <= '0;
        end else begin
            id_ex         <= dec;
            id_ex.rs1_val <= rs1_val;
            id_ex.rs2_val <= rs2_val;
        end
    end

    a_bubble_on_hazard: assert property (
        @(posedge clk) disable iff (!arst_n) (stall || branch_taken) |=> !id_ex.valid
    );

endmodule

`default_nettype wire

//--- logic/forwarding_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit (
    input  pipe_pkg::id_ex_t   id_ex,
    input  pipe_pkg::ex_mem_t  ex_mem,
    input  pipe_pkg::wb_t      wb,
    output pipe_pkg::fwd_sel_e fwd_a,
    output pipe_pkg::fwd_sel_e fwd_b
);

    // EX/MEM first since it is younger; loads there are handled by the stall
    function automatic pipe_pkg::fwd_sel_e pick(input pipe_pkg::reg_idx_t src);
        if (src == '0) begin
            return pipe_pkg::fwd_reg;
        end else if (ex_mem.valid && ex_mem.rd_we && !ex_mem.is_load && ex_mem.rd == src) begin
            return pipe_pkg::fwd_exmem;
        end else if (wb.we && wb.rd == src) begin
            return pipe_pkg::fwd_wb;
        end
        return pipe_pkg::fwd_reg;
    endfunction

    assign fwd_a = pick(id_ex.rs1);
    assign fwd_b = pick(id_ex.rs2);

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  pipe_pkg::id_ex_t   id_ex,
    input  pipe_pkg::fwd_sel_e fwd_a,
    input  pipe_pkg::fwd_sel_e fwd_b,
    input  pipe_pkg::wb_t      wb,
    output pipe_pkg::ex_mem_t  ex_mem,
    output logic               branch_taken,
    output pipe_pkg::word_t    branch_target
);

    pipe_pkg::word_t   op_a;
    pipe_pkg::word_t   op_b;
    pipe_pkg::word_t   alu_b;
    pipe_pkg::word_t   alu_y;
    pipe_pkg::ex_mem_t ex_next;

    function automatic pipe_pkg::word_t fwd_mux(input pipe_pkg::fwd_sel_e sel,
                                                input pipe_pkg::word_t    reg_val);
        case (sel)
            pipe_pkg::fwd_exmem: return ex_mem.result;
            pipe_pkg::fwd_wb:    return wb.value;
            default:             return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a, id_ex.rs1_val);
    assign op_b  = fwd_mux(fwd_b, id_ex.rs2_val);
    assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

    // Loads and stores use the add path for rs1 + imm
    always_comb begin
        case (id_ex.alu_op)
            pipe_pkg::alu_sub: alu_y = op_a - alu_b;
            pipe_pkg::alu_and: alu_y = op_a & alu_b;
            pipe_pkg::alu_or:  alu_y = op_a | alu_b;
            pipe_pkg::alu_xor: alu_y = op_a ^ alu_b;
            pipe_pkg::alu_slt: alu_y = {31'd0, $signed(op_a) < $signed(alu_b)};
            default:           alu_y = op_a + alu_b;
        endcase
    end

    // BEQ on equal, BNE on not equal
    assign branch_taken  = id_ex.valid && id_ex.is_branch &&
                           ((op_a == op_b) != id_ex.branch_ne);
    assign branch_target = id_ex.pc + id_ex.imm;

    always_comb begin
        ex_next            = '0;
        ex_next.valid      = id_ex.valid;
        ex_next.rd         = id_ex.rd;
        ex_next.rd_we      = id_ex.rd_we;
        ex_next.result     = alu_y;
        ex_next.store_data = op_b;
        ex_next.is_load    = id_ex.is_load;
        ex_next.is_store   = id_ex.is_store;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_next;
        end
    end

    // A taken branch comes from a real branch, and the slot behind it is flushed
    a_branch_flush: assert property (
        @(posedge clk) disable iff (!arst_n)
        branch_taken |-> (id_ex.valid && id_ex.is_branch) ##1 !id_ex.valid
    );

endmodule

`default_nettype wire

//--- logic/memwb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memwb_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  pipe_pkg::ex_mem_t  ex_mem,
    input  pipe_pkg::word_t    read_data,
    output pipe_pkg::mem_req_t mem_req,
    output pipe_pkg::wb_t      wb
);

    pipe_pkg::mem_wb_t mem_wb;

    assign mem_req.rd_en   = ex_mem.valid && ex_mem.is_load;
    assign mem_req.wr_en   = ex_mem.valid && ex_mem.is_store;
    assign mem_req.addr    = ex_mem.result;
    assign mem_req.wr_data = ex_mem.store_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.rd_we     <= ex_mem.rd_we;
            mem_wb.is_load   <= ex_mem.is_load;
            mem_wb.result    <= ex_mem.result;
            mem_wb.load_data <= read_data;
        end
    end

    // Writeback value
    assign wb.we    = mem_wb.valid && mem_wb.rd_we;
    assign wb.rd    = mem_wb.rd;
    assign wb.value = mem_wb.is_load ? mem_wb.load_data : mem_wb.result;

    a_one_strobe: assert property (
        @(posedge clk) disable iff (!arst_n) !(mem_req.rd_en && mem_req.wr_en)
    );

endmodule

`default_nettype wire

//--- logic/riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [rv_isa_pkg::xlen-1:0] instr,
    input  logic [rv_isa_pkg::xlen-1:0] read_data,
    output logic [rv_isa_pkg::xlen-1:0] pc,
    output pipe_pkg::mem_req_t          mem_req
);

    logic [rv_isa_pkg::xlen-1:0] if_pc;
    rv_isa_pkg::instr_u          if_instr;
    logic                        stall;
    logic                        branch_taken;
    pipe_pkg::word_t             branch_target;
    pipe_pkg::reg_idx_t          rs1;
    pipe_pkg::reg_idx_t          rs2;
    pipe_pkg::word_t             rs1_val;
    pipe_pkg::word_t             rs2_val;
    pipe_pkg::id_ex_t            id_ex;
    pipe_pkg::ex_mem_t           ex_mem;
    pipe_pkg::wb_t               wb;
    pipe_pkg::fwd_sel_e          fwd_a;
    pipe_pkg::fwd_sel_e          fwd_b;

    fetch_stage fetch0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .instr         (instr),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc),
        .if_pc         (if_pc),
        .if_instr      (if_instr)
    );

    decode_stage decode0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .if_pc        (if_pc),
        .if_instr     (if_instr),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .branch_taken (branch_taken),
        .rs1          (rs1),
        .rs2          (rs2),
        .stall        (stall),
        .id_ex        (id_ex)
    );

    // Read in decode, written from writeback
    register_file regs0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .wb      (wb),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    forwarding_unit fwd0 (
        .id_ex  (id_ex),
        .ex_mem (ex_mem),
        .wb     (wb),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b)
    );

    execute_stage execute0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .id_ex         (id_ex),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .wb            (wb),
        .ex_mem        (ex_mem),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    memwb_stage memwb0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .ex_mem    (ex_mem),
        .read_data (read_data),
        .mem_req   (mem_req),
        .wb        (wb)
    );

endmodule

`default_nettype wire

//--- bench/tb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory (
    input  logic               clk,
    input  logic               arst_n,
    input  pipe_pkg::word_t    pc,
    input  pipe_pkg::mem_req_t mem_req,
    output pipe_pkg::word_t    instr,
    output pipe_pkg::word_t    read_data,
    output int                 faults
);

    // 64 words each, word addressed
    pipe_pkg::word_t rom [0:63];
    pipe_pkg::word_t ram [0:63];
    integer          seed;
    int              fault_count = 0;

    assign faults = fault_count;

    initial begin
        seed = 32'h2b23;
        for (int i = 0; i < 64; i++) begin
            ram[i[5:0]] <= $random(seed);
        end
    end

    // Both memories answer in the same cycle
    assign instr     = rom[pc[7:2]];
    assign read_data = ram[mem_req.addr[7:2]];

    always @(posedge clk) begin
        if (mem_req.wr_en) begin
            ram[mem_req.addr[7:2]] <= mem_req.wr_data;
        end
    end

    store_target: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req.wr_en |-> (mem_req.addr[1:0] == 2'b00 && mem_req.addr < 32'd256))
    else begin
        fault_count = fault_count + 1;
        $display("t=%0t store to %h is unaligned or outside the data RAM",
                 $time, $sampled(mem_req.addr));
    end

    load_target: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req.rd_en |-> (mem_req.addr[1:0] == 2'b00 && mem_req.addr < 32'd256))
    else begin
        fault_count = fault_count + 1;
        $display("t=%0t load from %h is unaligned or outside the data RAM",
                 $time, $sampled(mem_req.addr));
    end

    // Program never runs off the end of the ROM
    fetch_target: assert property (@(posedge clk) disable iff (!arst_n) pc < 32'd256)
    else begin
        fault_count = fault_count + 1;
        $display("t=%0t fetch from %h is outside the instruction ROM", $time, $sampled(pc));
    end

endmodule

`default_nettype wire

//--- bench/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam logic [4:0] n_stores = 5'd10;

    logic               clk;
    logic               arst_n;
    pipe_pkg::word_t    instr;
    pipe_pkg::word_t    read_data;
    pipe_pkg::word_t    pc;
    pipe_pkg::mem_req_t mem_req;
    int                 faults;
    int                 errors = 0;
    int                 failed_tests = 0;
    int                 err_mark;
    int                 hold_count = 0;
    pipe_pkg::word_t    hold_pc = '0;
    pipe_pkg::word_t    prev_pc = '0;
    logic               prev_live = 1'b0;
    logic               linear_phase;
    logic [4:0]         store_idx = '0;
    logic [5:0]         rom_at;
    pipe_pkg::word_t    exp_addr [0:31];
    pipe_pkg::word_t    exp_data [0:31];

    riscv_core dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .instr     (instr),
        .read_data (read_data),
        .pc        (pc),
        .mem_req   (mem_req)
    );

    tb_memory mem0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .pc        (pc),
        .mem_req   (mem_req),
        .instr     (instr),
        .read_data (read_data),
        .faults    (faults)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Store counter and pc hold tracker
    always @(posedge clk) begin
        if (arst_n && mem_req.wr_en) begin
            store_idx <= store_idx + 5'd1;
        end
        if (arst_n && prev_live && pc == prev_pc) begin
            hold_count <= hold_count + 1;
            hold_pc    <= pc;
        end
        prev_pc   <= pc;
        prev_live <= arst_n;
    end

    // No stall or branch below this address
    assign linear_phase = pc < 32'd64;

    reset_state: assert property (@(posedge clk)
        !arst_n |=> (pc == 32'd0 && !mem_req.rd_en && !mem_req.wr_en))
    else begin
        errors = errors + 1;
        $display("MISMATCH t=%0t pc,rd_en,wr_en expected %h,0,0 got %h,%b,%b",
                 $time, 32'd0, $sampled(pc), $sampled(mem_req.rd_en),
                 $sampled(mem_req.wr_en));
    end

    pc_steps: assert property (@(posedge clk) disable iff (!arst_n)
        (linear_phase && prev_live) |-> pc == prev_pc + 32'd4)
    else begin
        errors = errors + 1;
        $display("MISMATCH t=%0t pc expected %h got %h",
                 $time, $sampled(prev_pc) + 32'd4, $sampled(pc));
    end

    store_expected: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req.wr_en |-> store_idx < n_stores)
    else begin
        errors = errors + 1;
        $display("t=%0t unexpected extra store to %h", $time, $sampled(mem_req.addr));
    end

    store_addr_check: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_req.wr_en && store_idx < n_stores) |-> mem_req.addr == exp_addr[store_idx])
    else begin
        errors = errors + 1;
        $display("MISMATCH t=%0t mem_req.addr expected %h got %h",
                 $time, exp_addr[$sampled(store_idx)], $sampled(mem_req.addr));
    end

    store_data_check: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_req.wr_en && store_idx < n_stores) |-> mem_req.wr_data == exp_data[store_idx])
    else begin
        errors = errors + 1;
        $display("MISMATCH t=%0t mem_req.wr_data expected %h got %h",
                 $time, exp_data[$sampled(store_idx)], $sampled(mem_req.wr_data));
    end

    // The two stores behind the taken BEQ target 92 and 96
    flushed_stores: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req.wr_en |-> (mem_req.addr != 32'd92 && mem_req.addr != 32'd96))
    else begin
        errors = errors + 1;
        $display("t=%0t store from a flushed slot reached memory at %h",
                 $time, $sampled(mem_req.addr));
    end

    branch_lands: assert property (@(posedge clk) disable iff (!arst_n)
        $past(pc, 3) == 32'd72 |-> pc == 32'd88)
    else begin
        errors = errors + 1;
        $display("MISMATCH t=%0t pc expected %h got %h", $time, 32'd88, $sampled(pc));
    end

    function automatic pipe_pkg::word_t rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                                   input logic [4:0] rd, input logic [4:0] rs1,
                                                   input logic [4:0] rs2);
        rv_isa_pkg::instr_u w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = rv_isa_pkg::op_rtype;
        return w;
    endfunction

    function automatic pipe_pkg::word_t itype_word(input logic [6:0] opcode,
                                                   input logic [2:0] f3, input logic [4:0] rd,
                                                   input logic [4:0] rs1, input logic [11:0] imm);
        rv_isa_pkg::instr_u w;
        w.i.imm    = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = opcode;
        return w;
    endfunction

    function automatic pipe_pkg::word_t store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                                   input logic [11:0] imm);
        rv_isa_pkg::instr_u w;
        w.s.imm_hi = imm[11:5];
        w.s.rs2    = rs2;
        w.s.rs1    = rs1;
        w.s.funct3 = rv_isa_pkg::f3_sw;
        w.s.imm_lo = imm[4:0];
        w.s.opcode = rv_isa_pkg::op_store;
        return w;
    endfunction

    // Offset is in bytes, bit 0 dropped
    function automatic pipe_pkg::word_t branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                    input logic [4:0] rs2, input logic [12:0] off);
        rv_isa_pkg::instr_u w;
        w.b.imm12   = off[12];
        w.b.imm10_5 = off[10:5];
        w.b.rs2     = rs2;
        w.b.rs1     = rs1;
        w.b.funct3  = f3;
        w.b.imm4_1  = off[4:1];
        w.b.imm11   = off[11];
        w.b.opcode  = rv_isa_pkg::op_branch;
        return w;
    endfunction

    task automatic emit(input pipe_pkg::word_t word);
        mem0.rom[rom_at] = word;
        rom_at = rom_at + 6'd1;
    endtask

    task automatic load_program();
        for (int i = 0; i < 64; i++) begin
            mem0.rom[i[5:0]] = rv_isa_pkg::nop_instr;
        end
        rom_at = '0;
        emit(itype_word(rv_isa_pkg::op_load, rv_isa_pkg::f3_lw, 5'd1, 5'd0, 12'd0));
        emit(itype_word(rv_isa_pkg::op_load, rv_isa_pkg::f3_lw, 5'd2, 5'd0, 12'd4));
        emit(itype_word(rv_isa_pkg::op_itype_alu, rv_isa_pkg::f3_add_sub, 5'd3, 5'd0, 12'h123));
        // ALU chain, each result feeds the next
        emit(rtype_word(rv_isa_pkg::f7_base, rv_isa_pkg::f3_add_sub, 5'd4, 5'd1, 5'd2));
        emit(rtype_word(rv_isa_pkg::f7_sub, rv_isa_pkg::f3_add_sub, 5'd5, 5'd4, 5'd3));
        emit(rtype_word(rv_isa_pkg::f7_base, rv_isa_pkg::f3_xor, 5'd6, 5'd5, 5'd1));
        emit(rtype_word(rv_isa_pkg::f7_base, rv_isa_pkg::f3_or, 5'd7, 5'd4, 5'd6));
        emit(rtype_word(rv_isa_pkg::f7_base, rv_isa_pkg::f3_and, 5'd8, 5'd7, 5'd5));
        emit(rtype_word(rv_isa_pkg::f7_base, rv_isa_pkg::f3_slt, 5'd9, 5'd5, 5'd2));
        emit(store_word(5'd4, 5'd0, 12'd64));
        emit(store_word(5'd5, 5'd0, 12'd68));
        emit(store_word(5'd6, 5'd0, 12'd72));
        emit(store_word(5'd7, 5'd0, 12'd76));
        emit(store_word(5'd8, 5'd0, 12'd80));
        emit(store_word(5'd9, 5'd0, 12'd84));
        // Load-use pair at pc 60 and 64
        emit(itype_word(rv_isa_pkg::op_load, rv_isa_pkg::f3_lw, 5'd10, 5'd0, 12'd8));
        emit(rtype_word(rv_isa_pkg::f7_base, rv_isa_pkg::f3_add_sub, 5'd11, 5'd10, 5'd3));
        emit(store_word(5'd11, 5'd0, 12'd88));
        // Taken BEQ at pc 72 to pc 88
        emit(branch_word(rv_isa_pkg::f3_beq, 5'd1, 5'd1, 13'd16));
        emit(store_word(5'd4, 5'd0, 12'd92));
        emit(store_word(5'd5, 5'd0, 12'd96));
        emit(rv_isa_pkg::nop_instr);
        emit(store_word(5'd3, 5'd0, 12'd104));
        emit(branch_word(rv_isa_pkg::f3_bne, 5'd1, 5'd1, 13'd16));
        emit(store_word(5'd2, 5'd0, 12'd108));
        emit(itype_word(rv_isa_pkg::op_itype_alu, rv_isa_pkg::f3_add_sub, 5'd0, 5'd0, 12'd5));
        emit(store_word(5'd0, 5'd0, 12'd112));
        // Parks the core in a loop
        emit(branch_word(rv_isa_pkg::f3_beq, 5'd0, 5'd0, 13'd0));
    endtask

    // Register values follow the RV32I rules for the program above
    task automatic build_expected();
        pipe_pkg::word_t g1;
        pipe_pkg::word_t g2;
        pipe_pkg::word_t g3;
        pipe_pkg::word_t g4;
        pipe_pkg::word_t g5;
        pipe_pkg::word_t g6;
        pipe_pkg::word_t g7;
        pipe_pkg::word_t g8;
        pipe_pkg::word_t g9;
        pipe_pkg::word_t g11;
        g1  = mem0.ram[6'd0];
        g2  = mem0.ram[6'd1];
        g3  = 32'h0000_0123;
        g4  = g1 + g2;
        g5  = g4 - g3;
        g6  = g5 ^ g1;
        g7  = g4 | g6;
        g8  = g7 & g5;
        g9  = ($signed(g5) < $signed(g2)) ? 32'd1 : 32'd0;
        g11 = mem0.ram[6'd2] + g3;
        exp_addr[0] = 32'd64;
        exp_data[0] = g4;
        exp_addr[1] = 32'd68;
        exp_data[1] = g5;
        exp_addr[2] = 32'd72;
        exp_data[2] = g6;
        exp_addr[3] = 32'd76;
        exp_data[3] = g7;
        exp_addr[4] = 32'd80;
        exp_data[4] = g8;
        exp_addr[5] = 32'd84;
        exp_data[5] = g9;
        exp_addr[6] = 32'd88;
        exp_data[6] = g11;
        exp_addr[7] = 32'd104;
        exp_data[7] = g3;
        exp_addr[8] = 32'd108;
        exp_data[8] = g2;
        exp_addr[9] = 32'd112;
        exp_data[9] = 32'd0;
    endtask

    task automatic run_until_pc(input pipe_pkg::word_t target, input int limit);
        int n;
        n = 0;
        while (pc != target && n < limit) begin
            @(negedge clk);
            n = n + 1;
        end
        if (pc != target) begin
            errors = errors + 1;
            $display("t=%0t timeout, pc did not reach %h within %0d cycles", $time, target, limit);
        end
    endtask

    task automatic drain_stores(input logic [4:0] count, input int limit);
        int n;
        n = 0;
        while (store_idx < count && n < limit) begin
            @(negedge clk);
            n = n + 1;
        end
        if (store_idx < count) begin
            errors = errors + 1;
            $display("t=%0t timeout, only %0d of %0d stores seen", $time, store_idx, count);
        end
    endtask

    task automatic report_test(input string name, input int mark);
        if (errors + faults == mark) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests = failed_tests + 1;
            $display("test %s: failed with %0d errors", name, errors + faults - mark);
        end
    endtask

    initial begin
        arst_n = 1'b0;
        load_program();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        build_expected();

        err_mark = errors + faults;
        run_until_pc(32'd64, 40);
        report_test("reset and sequential fetch", err_mark);

        err_mark = errors + faults;
        drain_stores(5'd6, 60);
        report_test("forwarded ALU chain", err_mark);

        err_mark = errors + faults;
        drain_stores(5'd7, 40);
        assert (hold_count == 1) else begin
            errors = errors + 1;
            $display("MISMATCH t=%0t hold_count expected 1 got %0d", $time, hold_count);
        end
        assert (hold_pc == 32'd68) else begin
            errors = errors + 1;
            $display("MISMATCH t=%0t hold_pc expected %h got %h", $time, 32'd68, hold_pc);
        end
        report_test("load-use stall", err_mark);

        err_mark = errors + faults;
        drain_stores(5'd8, 40);
        report_test("taken BEQ flush", err_mark);

        err_mark = errors + faults;
        drain_stores(n_stores, 40);
        repeat (12) @(negedge clk);
        assert (store_idx == n_stores) else begin
            errors = errors + 1;
            $display("MISMATCH t=%0t store_idx expected %0d got %0d", $time, n_stores, store_idx);
        end
        report_test("BNE fall-through and x0", err_mark);

        $display("tests run 5, failed %0d, errors %0d", failed_tests, errors + faults);
        if (errors + faults == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/forwarding_unit.sv
logic/execute_stage.sv
logic/memwb_stage.sv
logic/riscv_core.sv
bench/tb_memory.sv
bench/core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module core_tb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcore_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx '>>> PASS' sim.log; then
    exit 0
fi
exit 1
